// File: source/config_port_pkg.sv
package config_port_pkg;

	// ------------------------------------------------------------------
	// Bus geometry
	// ------------------------------------------------------------------

	// One beat is one full data word
	localparam int DATA_WIDTH = 32;
	localparam int ADDR_WIDTH = 32;
	// Byte lanes per beat
	localparam int STRB_WIDTH = DATA_WIDTH / 8;
	// First address bit of the row index
	localparam int ADDR_LSB = $clog2(STRB_WIDTH);

	// ------------------------------------------------------------------
	// Memory geometry
	// ------------------------------------------------------------------

	localparam int MEMORY_BYTES = 64;
	localparam int MEMORY_ROWS = MEMORY_BYTES / STRB_WIDTH;
	localparam int ROW_BITS = $clog2(MEMORY_ROWS);

	// Vector types
	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [STRB_WIDTH-1:0] strb_t;
	typedef logic [ROW_BITS-1:0] row_t;
	// AXI length field, beats minus one
	typedef logic [7:0] burst_len_t;
	// Flat image, row r byte b at bit 8*(4r+b)
	typedef logic [MEMORY_BYTES*8-1:0] image_t;

	// AXI burst encodings
	typedef enum logic [1:0] {
		BURST_FIXED    = 2'b00,
		BURST_INCR     = 2'b01,
		BURST_WRAP     = 2'b10,
		BURST_RESERVED = 2'b11
	} burst_t;

	// Response code
	typedef logic [1:0] resp_t;
	localparam resp_t RESP_OKAY = 2'b00;

	// Channel FSM states
	typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} write_state_t;
	typedef enum logic [1:0] {R_IDLE, R_FETCH, R_DATA} read_state_t;

endpackage

// File: source/config_memory.sv
`timescale 1ns/100ps

module config_memory (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic wr_en,
	input config_port_pkg::row_t wr_row,
	input config_port_pkg::data_t wr_data,
	input config_port_pkg::strb_t wr_strb,
	input logic rd_en,
	input config_port_pkg::row_t rd_row,
	output config_port_pkg::data_t rd_data,
	output config_port_pkg::image_t image
);

	// Register rows, one data word each
	config_port_pkg::data_t rows [config_port_pkg::MEMORY_ROWS];

	// ------------------------------------------------------------------
	// Write port
	// ------------------------------------------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			// Whole configuration goes back to zero
			for (int r = 0; r < config_port_pkg::MEMORY_ROWS; r++)
			begin
				rows[r] <= '0;
			end
		end
		else if (wr_en)
		begin
			// Only lanes with their strobe set are updated
			for (int b = 0; b < config_port_pkg::STRB_WIDTH; b++)
			begin
				if (wr_strb[b])
				begin
					rows[wr_row][8*b +: 8] <= wr_data[8*b +: 8];
				end
			end
		end
	end

	// Registered row read, held until the next request
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (rd_en)
		begin
			rd_data <= rows[rd_row];
		end
	end

	// Flat image, row 0 in the low bits
	always_comb
	begin
		for (int r = 0; r < config_port_pkg::MEMORY_ROWS; r++)
		begin
			image[config_port_pkg::DATA_WIDTH*r +: config_port_pkg::DATA_WIDTH] = rows[r];
		end
	end

endmodule

// File: source/axi_write_channel.sv
`timescale 1ns/100ps

module axi_write_channel (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input config_port_pkg::addr_t awaddr,
	input config_port_pkg::burst_len_t awlen,
	input config_port_pkg::burst_t awburst,
	input logic awvalid,
	output logic awready,
	input config_port_pkg::data_t wdata,
	input config_port_pkg::strb_t wstrb,
	input logic wlast,
	input logic wvalid,
	output logic wready,
	output config_port_pkg::resp_t bresp,
	output logic bvalid,
	input logic bready,
	input logic read_busy,
	output logic write_busy,
	output logic wr_en,
	output config_port_pkg::row_t wr_row,
	output config_port_pkg::data_t wr_data,
	output config_port_pkg::strb_t wr_strb
);

	config_port_pkg::write_state_t state;
	// Latched burst
	config_port_pkg::row_t row;
	config_port_pkg::burst_len_t len;
	config_port_pkg::burst_t burst;
	config_port_pkg::burst_len_t beat_count;
	logic aw_accepted;
	logic beat_accepted;
	logic final_beat;

	assign aw_accepted = awvalid && awready;
	assign beat_accepted = wvalid && wready;
	// WLAST ends the burst, the length counter is a backstop
	assign final_beat = wlast || (beat_count == len);

	// Busy also covers the AWREADY pulse so a read cannot slip in
	assign write_busy = (state != config_port_pkg::W_IDLE) || awready;
	// Every write completes without error
	assign bresp = config_port_pkg::RESP_OKAY;

	// One memory write per accepted beat, same edge
	assign wr_en = beat_accepted;
	assign wr_row = row;
	assign wr_data = wdata;
	assign wr_strb = wstrb;

	// ------------------------------------------------------------------
	// Control FSM
	// ------------------------------------------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state <= config_port_pkg::W_IDLE;
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
		end
		else
		begin
			// AWREADY is a single-cycle pulse
			awready <= 1'b0;
			case (state)
				config_port_pkg::W_IDLE:
				begin
					if (aw_accepted)
					begin
						state <= config_port_pkg::W_DATA;
						wready <= 1'b1;
					end
					else if (awvalid && !awready && !read_busy)
					begin
						awready <= 1'b1;
					end
				end
				config_port_pkg::W_DATA:
				begin
					// Last beat closes the data phase
					if (beat_accepted && final_beat)
					begin
						wready <= 1'b0;
						bvalid <= 1'b1;
						state <= config_port_pkg::W_RESP;
					end
				end
				config_port_pkg::W_RESP:
				begin
					// Bus stays owned until the response is taken
					if (bready)
					begin
						bvalid <= 1'b0;
						state <= config_port_pkg::W_IDLE;
					end
				end
				default: state <= config_port_pkg::W_IDLE;
			endcase
		end
	end

	// Burst address and beat tracking
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (aw_accepted)
		begin
			row <= awaddr[config_port_pkg::ADDR_LSB +: config_port_pkg::ROW_BITS];
			len <= awlen;
			burst <= awburst;
			beat_count <= '0;
		end
		else if (beat_accepted)
		begin
			beat_count <= beat_count + 1'b1;
			// WRAP and reserved step like INCR, row wraps modulo memory size
			if (burst != config_port_pkg::BURST_FIXED)
			begin
				row <= row + 1'b1;
			end
		end
	end

endmodule

// File: source/axi_read_channel.sv
`timescale 1ns/100ps

module axi_read_channel (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input config_port_pkg::addr_t araddr,
	input config_port_pkg::burst_len_t arlen,
	input config_port_pkg::burst_t arburst,
	input logic arvalid,
	output logic arready,
	input logic awvalid,
	input logic write_busy,
	output logic read_busy,
	output logic rd_en,
	output config_port_pkg::row_t rd_row,
	input config_port_pkg::data_t rd_data,
	output config_port_pkg::data_t rdata,
	output config_port_pkg::resp_t rresp,
	output logic rlast,
	output logic rvalid,
	input logic rready
);

	config_port_pkg::read_state_t state;
	// Latched burst
	config_port_pkg::row_t row;
	config_port_pkg::burst_len_t len;
	config_port_pkg::burst_t burst;
	config_port_pkg::burst_len_t beat_count;
	logic ar_accepted;
	logic beat_accepted;

	assign ar_accepted = arvalid && arready;
	assign beat_accepted = rvalid && rready;

	// Busy also covers the ARREADY pulse
	assign read_busy = (state != config_port_pkg::R_IDLE) || arready;

	// One fetch cycle per beat
	assign rd_en = (state == config_port_pkg::R_FETCH);
	assign rd_row = row;

	// Data bus is quiet outside valid beats
	assign rdata = rvalid ? rd_data : '0;
	assign rresp = config_port_pkg::RESP_OKAY;

	// ------------------------------------------------------------------
	// Control FSM
	// ------------------------------------------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state <= config_port_pkg::R_IDLE;
			arready <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
		end
		else
		begin
			// ARREADY is a single-cycle pulse
			arready <= 1'b0;
			case (state)
				config_port_pkg::R_IDLE:
				begin
					if (ar_accepted)
					begin
						state <= config_port_pkg::R_FETCH;
					end
					// A pending write address wins the tie
					else if (arvalid && !arready && !write_busy && !awvalid)
					begin
						arready <= 1'b1;
					end
				end
				config_port_pkg::R_FETCH:
				begin
					// Row lands in rd_data on this edge
					rvalid <= 1'b1;
					rlast <= (beat_count == len);
					state <= config_port_pkg::R_DATA;
				end
				config_port_pkg::R_DATA:
				begin
					// Held beat while RREADY is low
					if (beat_accepted)
					begin
						rvalid <= 1'b0;
						rlast <= 1'b0;
						if (rlast)
						begin
							state <= config_port_pkg::R_IDLE;
						end
						else
						begin
							state <= config_port_pkg::R_FETCH;
						end
					end
				end
				default: state <= config_port_pkg::R_IDLE;
			endcase
		end
	end

	// Burst address and beat tracking
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (ar_accepted)
		begin
			row <= araddr[config_port_pkg::ADDR_LSB +: config_port_pkg::ROW_BITS];
			len <= arlen;
			burst <= arburst;
			beat_count <= '0;
		end
		else if (beat_accepted)
		begin
			beat_count <= beat_count + 1'b1;
			// FIXED rereads the same row, all other types increment
			if (burst != config_port_pkg::BURST_FIXED)
			begin
				row <= row + 1'b1;
			end
		end
	end

endmodule

// File: source/config_port.sv
`timescale 1ns/100ps

module config_port (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// Write address channel
	input config_port_pkg::addr_t S_AXI_AWADDR,
	input config_port_pkg::burst_len_t S_AXI_AWLEN,
	input config_port_pkg::burst_t S_AXI_AWBURST,
	input logic S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	// Write data channel
	input config_port_pkg::data_t S_AXI_WDATA,
	input config_port_pkg::strb_t S_AXI_WSTRB,
	input logic S_AXI_WLAST,
	input logic S_AXI_WVALID,
	output logic S_AXI_WREADY,
	// Write response channel
	output config_port_pkg::resp_t S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input logic S_AXI_BREADY,
	// Read address channel
	input config_port_pkg::addr_t S_AXI_ARADDR,
	input config_port_pkg::burst_len_t S_AXI_ARLEN,
	input config_port_pkg::burst_t S_AXI_ARBURST,
	input logic S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	// Read data channel
	output config_port_pkg::data_t S_AXI_RDATA,
	output config_port_pkg::resp_t S_AXI_RRESP,
	output logic S_AXI_RLAST,
	output logic S_AXI_RVALID,
	input logic S_AXI_RREADY,
	// Configuration image for downstream logic
	output config_port_pkg::image_t memory_out
);

	// Mutual exclusion between the channels
	logic write_busy;
	logic read_busy;
	// Memory write port
	logic wr_en;
	config_port_pkg::row_t wr_row;
	config_port_pkg::data_t wr_data;
	config_port_pkg::strb_t wr_strb;
	// Memory read port
	logic rd_en;
	config_port_pkg::row_t rd_row;
	config_port_pkg::data_t rd_data;

	// ------------------------------------------------------------------
	// Channels
	// ------------------------------------------------------------------

	axi_write_channel write_i (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.awaddr(S_AXI_AWADDR),
		.awlen(S_AXI_AWLEN),
		.awburst(S_AXI_AWBURST),
		.awvalid(S_AXI_AWVALID),
		.awready(S_AXI_AWREADY),
		.wdata(S_AXI_WDATA),
		.wstrb(S_AXI_WSTRB),
		.wlast(S_AXI_WLAST),
		.wvalid(S_AXI_WVALID),
		.wready(S_AXI_WREADY),
		.bresp(S_AXI_BRESP),
		.bvalid(S_AXI_BVALID),
		.bready(S_AXI_BREADY),
		.read_busy(read_busy),
		.write_busy(write_busy),
		.wr_en(wr_en),
		.wr_row(wr_row),
		.wr_data(wr_data),
		.wr_strb(wr_strb)
	);

	// AWVALID feeds in so a simultaneous write takes priority
	axi_read_channel read_i (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.araddr(S_AXI_ARADDR),
		.arlen(S_AXI_ARLEN),
		.arburst(S_AXI_ARBURST),
		.arvalid(S_AXI_ARVALID),
		.arready(S_AXI_ARREADY),
		.awvalid(S_AXI_AWVALID),
		.write_busy(write_busy),
		.read_busy(read_busy),
		.rd_en(rd_en),
		.rd_row(rd_row),
		.rd_data(rd_data),
		.rdata(S_AXI_RDATA),
		.rresp(S_AXI_RRESP),
		.rlast(S_AXI_RLAST),
		.rvalid(S_AXI_RVALID),
		.rready(S_AXI_RREADY)
	);

	// Register memory
	config_memory memory_i (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.wr_en(wr_en),
		.wr_row(wr_row),
		.wr_data(wr_data),
		.wr_strb(wr_strb),
		.rd_en(rd_en),
		.rd_row(rd_row),
		.rd_data(rd_data),
		.image(memory_out)
	);

endmodule

// File: verif/config_port_properties.sv
`timescale 1ns/100ps

module config_port_properties (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic S_AXI_WREADY,
	input config_port_pkg::resp_t S_AXI_BRESP,
	input logic S_AXI_BVALID,
	input logic S_AXI_BREADY,
	input config_port_pkg::data_t S_AXI_RDATA,
	input logic S_AXI_RLAST,
	input logic S_AXI_RVALID,
	input logic S_AXI_RREADY
);

	// Failed property count, read by the testbench at the end
	int violations = 0;

	// ------------------------------------------------------------------
	// Handshake stability
	// ------------------------------------------------------------------

	// Stalled write response is held
	bvalid_holds: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID && $stable(S_AXI_BRESP))
	else
	begin
		$error("BVALID or BRESP changed before BREADY");
		violations++;
	end

	// Stalled read beat keeps data and last flag
	rvalid_holds: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID && !S_AXI_RREADY |=>
		S_AXI_RVALID && $stable(S_AXI_RDATA) && $stable(S_AXI_RLAST))
	else
	begin
		$error("RVALID, RDATA or RLAST changed before RREADY");
		violations++;
	end

	// Quiet read bus
	rdata_idle_zero: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!S_AXI_RVALID |-> S_AXI_RDATA == '0)
	else
	begin
		$error("RDATA nonzero while RVALID is low");
		violations++;
	end

	// One transaction at a time
	no_overlap: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!(S_AXI_WREADY && S_AXI_RVALID))
	else
	begin
		$error("WREADY and RVALID high together");
		violations++;
	end

endmodule

bind config_port config_port_properties props_i (
	.S_AXI_ACLK(S_AXI_ACLK),
	.S_AXI_ARESETN(S_AXI_ARESETN),
	.S_AXI_WREADY(S_AXI_WREADY),
	.S_AXI_BRESP(S_AXI_BRESP),
	.S_AXI_BVALID(S_AXI_BVALID),
	.S_AXI_BREADY(S_AXI_BREADY),
	.S_AXI_RDATA(S_AXI_RDATA),
	.S_AXI_RLAST(S_AXI_RLAST),
	.S_AXI_RVALID(S_AXI_RVALID),
	.S_AXI_RREADY(S_AXI_RREADY)
);

// File: verif/config_port_tb.sv
`timescale 1ns/100ps

module config_port_tb;

	localparam logic [31:0] SEED = 32'h3bc36df1;
	localparam int RESET_CYCLES = 16;
	// Pair count per test and max beats per pair (8 write plus 8 read)
	localparam int PAIRS = 8 + 8 + 4 + 4 + 8;
	localparam int TOTAL_BEATS = 16 + PAIRS * 16;
	localparam int CYCLE_LIMIT = 20 * TOTAL_BEATS + RESET_CYCLES;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	config_port_pkg::addr_t S_AXI_AWADDR;
	config_port_pkg::burst_len_t S_AXI_AWLEN;
	config_port_pkg::burst_t S_AXI_AWBURST;
	logic S_AXI_AWVALID;
	logic S_AXI_AWREADY;
	config_port_pkg::data_t S_AXI_WDATA;
	config_port_pkg::strb_t S_AXI_WSTRB;
	logic S_AXI_WLAST;
	logic S_AXI_WVALID;
	logic S_AXI_WREADY;
	config_port_pkg::resp_t S_AXI_BRESP;
	logic S_AXI_BVALID;
	logic S_AXI_BREADY;
	config_port_pkg::addr_t S_AXI_ARADDR;
	config_port_pkg::burst_len_t S_AXI_ARLEN;
	config_port_pkg::burst_t S_AXI_ARBURST;
	logic S_AXI_ARVALID;
	logic S_AXI_ARREADY;
	config_port_pkg::data_t S_AXI_RDATA;
	config_port_pkg::resp_t S_AXI_RRESP;
	logic S_AXI_RLAST;
	logic S_AXI_RVALID;
	logic S_AXI_RREADY;
	config_port_pkg::image_t memory_out;

	// Reference model with one entry per byte address
	logic [7:0] model [config_port_pkg::MEMORY_BYTES];
	logic [31:0] lfsr_state;
	// Random BREADY and RREADY when set
	logic stall_ready;
	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int errors_at_start;
	int cycles;
	string test_name;

	config_port dut_i (.*);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #20 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// ------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	// Row word from model bytes with byte 0 in the low lane
	function automatic config_port_pkg::data_t model_row(input config_port_pkg::row_t row);
		int base;
		base = int'(row) * config_port_pkg::STRB_WIDTH;
		return {model[base + 3], model[base + 2], model[base + 1], model[base]};
	endfunction

	// Byte a sits at bit 8a of the image
	function automatic config_port_pkg::image_t model_image();
		config_port_pkg::image_t image;
		for (int a = 0; a < config_port_pkg::MEMORY_BYTES; a++)
		begin
			image[8*a +: 8] = model[a];
		end
		return image;
	endfunction

	task automatic next_cycle();
		@(posedge S_AXI_ACLK);
		#2;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_image();
		config_port_pkg::image_t expected;
		expected = model_image();
		checks++;
		assert (memory_out === expected)
		else
		begin
			$display("MISMATCH memory_out expected %h actual %h", expected, memory_out);
			errors++;
		end
	endtask

	// ------------------------------------------------------------------
	// Bus tasks
	// ------------------------------------------------------------------

	task automatic write_burst(input config_port_pkg::addr_t addr, input int beats,
		input config_port_pkg::burst_t burst, input logic random_strobes);
		config_port_pkg::row_t row;
		int beat;
		logic accepted;
		logic done;
		row = addr[config_port_pkg::ADDR_LSB +: config_port_pkg::ROW_BITS];
		beat = 0;
		done = 1'b0;
		S_AXI_AWADDR = addr;
		S_AXI_AWLEN = config_port_pkg::burst_len_t'(beats - 1);
		S_AXI_AWBURST = burst;
		S_AXI_AWVALID = 1'b1;
		@(negedge S_AXI_ACLK);
		while (!S_AXI_AWREADY)
		begin
			next_cycle();
			@(negedge S_AXI_ACLK);
		end
		next_cycle();
		S_AXI_AWVALID = 1'b0;
		while (beat < beats)
		begin
			// New beat unless one is waiting and a gap one time in four
			if (!S_AXI_WVALID && random_bits(2) != 0)
			begin
				S_AXI_WDATA = random_bits(32);
				S_AXI_WSTRB = random_strobes ? config_port_pkg::strb_t'(random_bits(4)) : '1;
				S_AXI_WLAST = (beat == beats - 1);
				S_AXI_WVALID = 1'b1;
			end
			@(negedge S_AXI_ACLK);
			accepted = S_AXI_WVALID && S_AXI_WREADY;
			if (accepted)
			begin
				for (int b = 0; b < config_port_pkg::STRB_WIDTH; b++)
				begin
					if (S_AXI_WSTRB[b])
					begin
						model[config_port_pkg::STRB_WIDTH*int'(row) + b] = S_AXI_WDATA[8*b +: 8];
					end
				end
				// Only FIXED keeps the row
				if (burst != config_port_pkg::BURST_FIXED)
				begin
					row = row + 1'b1;
				end
			end
			next_cycle();
			if (accepted)
			begin
				S_AXI_WVALID = 1'b0;
				S_AXI_WLAST = 1'b0;
				beat++;
			end
		end
		// Response phase
		while (!done)
		begin
			S_AXI_BREADY = stall_ready ? (random_bits(1) != 0) : 1'b1;
			@(negedge S_AXI_ACLK);
			if (S_AXI_BVALID && S_AXI_BREADY)
			begin
				check_value("BRESP", 32'(config_port_pkg::RESP_OKAY), 32'(S_AXI_BRESP));
				done = 1'b1;
			end
			next_cycle();
		end
		// A second response would show here
		@(negedge S_AXI_ACLK);
		check_value("BVALID", 32'(1'b0), 32'(S_AXI_BVALID));
		check_image();
		next_cycle();
	endtask

	task automatic read_burst(input config_port_pkg::addr_t addr, input int beats,
		input config_port_pkg::burst_t burst);
		config_port_pkg::row_t row;
		int beat;
		row = addr[config_port_pkg::ADDR_LSB +: config_port_pkg::ROW_BITS];
		beat = 0;
		S_AXI_ARADDR = addr;
		S_AXI_ARLEN = config_port_pkg::burst_len_t'(beats - 1);
		S_AXI_ARBURST = burst;
		S_AXI_ARVALID = 1'b1;
		@(negedge S_AXI_ACLK);
		while (!S_AXI_ARREADY)
		begin
			next_cycle();
			@(negedge S_AXI_ACLK);
		end
		next_cycle();
		S_AXI_ARVALID = 1'b0;
		while (beat < beats)
		begin
			S_AXI_RREADY = stall_ready ? (random_bits(1) != 0) : 1'b1;
			@(negedge S_AXI_ACLK);
			if (S_AXI_RVALID && S_AXI_RREADY)
			begin
				check_value("RDATA", model_row(row), S_AXI_RDATA);
				check_value("RRESP", 32'(config_port_pkg::RESP_OKAY), 32'(S_AXI_RRESP));
				// RLAST only on the final beat
				check_value("RLAST", 32'(beat == beats - 1), 32'(S_AXI_RLAST));
				if (burst != config_port_pkg::BURST_FIXED)
				begin
					row = row + 1'b1;
				end
				beat++;
			end
			next_cycle();
		end
		// A beat past arlen+1 would rise after one fetch cycle
		repeat (2)
		begin
			@(negedge S_AXI_ACLK);
			check_value("RVALID", 32'(1'b0), 32'(S_AXI_RVALID));
			next_cycle();
		end
	endtask

	// Mode 0 selects INCR, mode 1 FIXED and mode 2 a random type
	task automatic write_read_pair(input int mode, input logic random_strobes,
		input logic high_address);
		config_port_pkg::addr_t addr;
		config_port_pkg::burst_t burst;
		int beats;
		beats = int'(random_bits(3)) + 1;
		if (mode == 0)
		begin
			burst = config_port_pkg::BURST_INCR;
		end
		else if (mode == 1)
		begin
			burst = config_port_pkg::BURST_FIXED;
		end
		else
		begin
			burst = config_port_pkg::burst_t'(random_bits(2));
		end
		// High addresses must alias onto the 64 bytes
		if (high_address)
		begin
			addr = random_bits(32);
		end
		else
		begin
			addr = config_port_pkg::addr_t'(random_bits(config_port_pkg::ROW_BITS))
				<< config_port_pkg::ADDR_LSB;
		end
		write_burst(addr, beats, burst, random_strobes);
		read_burst(addr, beats, burst);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors > errors_at_start)
		begin
			tests_failed++;
			$display("Test %s: FAIL with %0d errors", test_name, errors - errors_at_start);
		end
		else
		begin
			$display("Test %s: pass", test_name);
		end
	endtask

	// ------------------------------------------------------------------
	// Watchdog
	// ------------------------------------------------------------------

	initial
	begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge S_AXI_ACLK);
			cycles++;
		end
		$display("Timeout after %0d cycles, a handshake never completed", CYCLE_LIMIT);
		$display("Something failed");
		$finish;
	end

	// ------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------

	initial
	begin
		S_AXI_ARESETN = 1'b0;
		S_AXI_AWADDR = '0;
		S_AXI_AWLEN = '0;
		S_AXI_AWBURST = config_port_pkg::BURST_INCR;
		S_AXI_AWVALID = 1'b0;
		S_AXI_WDATA = '0;
		S_AXI_WSTRB = '0;
		S_AXI_WLAST = 1'b0;
		S_AXI_WVALID = 1'b0;
		S_AXI_BREADY = 1'b0;
		S_AXI_ARADDR = '0;
		S_AXI_ARLEN = '0;
		S_AXI_ARBURST = config_port_pkg::BURST_INCR;
		S_AXI_ARVALID = 1'b0;
		S_AXI_RREADY = 1'b0;
		lfsr_state = SEED;
		stall_ready = 1'b0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int a = 0; a < config_port_pkg::MEMORY_BYTES; a++)
		begin
			model[a] = 8'h00;
		end
		repeat (RESET_CYCLES) @(posedge S_AXI_ACLK);
		#2;
		S_AXI_ARESETN = 1'b1;
		next_cycle();

		start_test("reset_state");
		check_image();
		read_burst(config_port_pkg::addr_t'(0), 8, config_port_pkg::BURST_INCR);
		read_burst(config_port_pkg::addr_t'(32), 8, config_port_pkg::BURST_INCR);
		finish_test();

		start_test("incr_full_strobes");
		repeat (8) write_read_pair(0, 1'b0, 1'b0);
		finish_test();

		start_test("random_strobes");
		repeat (8) write_read_pair(2, 1'b1, 1'b0);
		finish_test();

		// Last beat merges over earlier ones in the same row
		start_test("fixed_bursts");
		repeat (4) write_read_pair(1, 1'b1, 1'b0);
		finish_test();

		start_test("address_wrap");
		repeat (4) write_read_pair(2, 1'b1, 1'b1);
		finish_test();

		start_test("ready_stalls");
		stall_ready = 1'b1;
		repeat (8) write_read_pair(2, 1'b1, 1'b1);
		finish_test();

		if (dut_i.props_i.violations != 0)
		begin
			$display("Handshake property failed %0d times", dut_i.props_i.violations);
			errors += dut_i.props_i.violations;
		end
		$display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
		begin
			$display("Everything OK");
		end
		else
		begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: src.f
source/config_port_pkg.sv
source/config_memory.sv
source/axi_write_channel.sv
source/axi_read_channel.sv
source/config_port.sv
verif/config_port_properties.sv
verif/config_port_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= config_port_tb
DUT_TOP ?= config_port
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
SEED_ARGS ?= +verilator+seed+1
RUN_ARGS ?= +verilator+error+limit+1000
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Everything OK

.PHONY: run build lint clean

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) $(SEED_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
